/* sources.f */
logic/rle_pkg.sv
logic/byte_fifo.sv
logic/run_detector.sv
logic/token_emitter.sv
logic/rle_encoder.sv
dv/rle_checker.sv
dv/rle_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the run-length encoder testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module rle_tb -Mdir obj_dir -o rle_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/rle_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed!"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* dv/rle_tb.sv */
`timescale 1ns/1ps

module rle_tb;

	import rle_pkg::*;

	logic       data_clk;
	logic       reset;
	data_byte_t data_in;
	logic       data_in_valid;
	logic       write_signal;
	logic       read_signal;
	data_byte_t data_out;
	logic       data_out_valid;
	logic       fifo_full;
	int         pending;
	int         chk_errors;
	int         tb_errors;

	// bytes the buffer should hold, in write order.
	data_byte_t stored_q[$];
	data_byte_t alphabet [4] = '{8'h00, 8'h41, 8'h42, ESCAPE_BYTE};
	data_byte_t esc_seq [7] = '{
		8'h41, ESCAPE_BYTE, 8'h42, ESCAPE_BYTE, ESCAPE_BYTE, 8'h43, ESCAPE_BYTE
	};

	rle_encoder dut_i (
		.data_clk       (data_clk),
		.reset          (reset),
		.data_in        (data_in),
		.data_in_valid  (data_in_valid),
		.write_signal   (write_signal),
		.read_signal    (read_signal),
		.data_out       (data_out),
		.data_out_valid (data_out_valid),
		.fifo_full      (fifo_full)
	);

	rle_checker chk_i (
		.data_clk       (data_clk),
		.reset          (reset),
		.data_in_valid  (data_in_valid),
		.write_signal   (write_signal),
		.read_signal    (read_signal),
		.data_out       (data_out),
		.data_out_valid (data_out_valid),
		.fifo_full      (fifo_full),
		.pending        (pending),
		.errors         (chk_errors)
	);

	always #50 data_clk = ~data_clk;

	// called at a falling edge.
	task automatic hold_reset();
		reset = 1'b1;
		read_signal = 1'b0;
		data_in_valid = 1'b0;
		write_signal = 1'b0;
		chk_i.clear_expected();
		stored_q.delete();
		repeat (8) @(negedge data_clk);
		reset = 1'b0;
	endtask

	task automatic put_byte(input data_byte_t b, input logic valid, input logic wsig);
		@(negedge data_clk);
		data_in = b;
		data_in_valid = valid;
		write_signal = wsig;
		if (valid && wsig && stored_q.size() < int'(FIFO_DEPTH)) begin
			stored_q.push_back(b);
		end
	endtask

	task automatic emit_run(input data_byte_t b, input int len);
		if (b == ESCAPE_BYTE || len > 2) begin
			chk_i.push_expected(ESCAPE_BYTE);
			chk_i.push_expected(8'(len));
			chk_i.push_expected(b);
		end else begin
			repeat (len) chk_i.push_expected(b);
		end
	endtask

	// model. split stored bytes into runs of at most MAX_RUN.
	task automatic expect_block();
		data_byte_t b;
		int len;
		b = '0;
		len = 0;
		foreach (stored_q[i]) begin
			if (len != 0 && (stored_q[i] != b || len == int'(MAX_RUN))) begin
				emit_run(b, len);
				len = 0;
			end
			b = stored_q[i];
			len++;
		end
		if (len != 0) begin
			emit_run(b, len);
		end
		stored_q.delete();
	endtask

	task automatic start_read();
		@(negedge data_clk);
		data_in_valid = 1'b0;
		write_signal = 1'b0;
		read_signal = 1'b1;
	endtask

	task automatic drain_block();
		int waited;
		expect_block();
		start_read();
		waited = 0;
		while (pending != 0 && waited < 3000) begin
			@(negedge data_clk);
			waited++;
		end
		if (pending != 0) begin
			$display("timeout: %0d expected output bytes never appeared", pending);
			tb_errors++;
			hold_reset();
		end else begin
			// short idle window so stray bytes get noticed.
			repeat (4) @(negedge data_clk);
			read_signal = 1'b0;
		end
	endtask

	task automatic random_block(input int n_runs);
		logic [1:0] k;
		int len;
		repeat (n_runs) begin
			k = 2'($urandom_range(3, 0));
			len = $urandom_range(6, 1);
			if ($urandom_range(7, 0) == 0) begin
				len = $urandom_range(40, 7);
			end
			repeat (len) put_byte(alphabet[k], 1'b1, 1'b1);
		end
	endtask

	task automatic mid_run_reset();
		int start;
		int waited;
		repeat (3) put_byte(8'h31, 1'b1, 1'b1);
		repeat (150) put_byte(8'h77, 1'b1, 1'b1);
		expect_block();
		start_read();
		start = pending;
		waited = 0;
		// reset while the first token is still going out and the long run is counted.
		while (pending > start - 1 && waited < 500) begin
			@(negedge data_clk);
			waited++;
		end
		if (pending > start - 1) begin
			$display("timeout: first token never started before the reset");
			tb_errors++;
		end
		hold_reset();
	endtask

	initial begin
		logic [1:0] strobes;
		data_clk = 1'b0;
		reset = 1'b1;
		data_in = '0;
		data_in_valid = 1'b0;
		write_signal = 1'b0;
		read_signal = 1'b0;
		tb_errors = 0;
		void'($urandom(32'ha2c54782));
		hold_reset();
		repeat (12) begin
			random_block(30);
			drain_block();
		end
		repeat (256) put_byte(8'h55, 1'b1, 1'b1);
		drain_block();
		foreach (esc_seq[i]) put_byte(esc_seq[i], 1'b1, 1'b1);
		drain_block();
		repeat (300) put_byte(alphabet[2'($urandom_range(3, 0))], 1'b1, 1'b1);
		drain_block();
		repeat (60) begin
			strobes = 2'($urandom_range(3, 0));
			put_byte(alphabet[2'($urandom_range(3, 0))], strobes[0], strobes[1]);
		end
		drain_block();
		mid_run_reset();
		random_block(20);
		drain_block();
		$display("checker errors: %0d, testbench errors: %0d", chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* dv/rle_checker.sv */
`timescale 1ns/1ps

module rle_checker (
	input  logic                data_clk,
	input  logic                reset,
	input  logic                data_in_valid,
	input  logic                write_signal,
	input  logic                read_signal,
	input  rle_pkg::data_byte_t data_out,
	input  logic                data_out_valid,
	input  logic                fifo_full,
	output int                  pending,
	output int                  errors
);

	import rle_pkg::*;

	data_byte_t  expect_q[$];
	data_byte_t  want;
	int unsigned stored;
	logic        full_model;
	logic        after_reset;

	initial begin
		pending = 0;
		errors = 0;
		stored = 0;
		after_reset = 1'b0;
	end

	task automatic push_expected(input data_byte_t b);
		expect_q.push_back(b);
	endtask

	task automatic clear_expected();
		expect_q.delete();
	endtask

	// outputs are registered, so the values seen here are the pre-edge ones.
	always @(posedge data_clk) begin
		// the emitter must come out of every reset edge silent.
		if (after_reset && data_out_valid) begin
			$display("FAILED at %0t: data_out_valid high after a reset edge", $time);
			errors++;
		end
		after_reset = reset;
		if (reset) begin
			stored = 0;
		end else begin
			if (data_out_valid) begin
				if (expect_q.size() == 0) begin
					$display("extra output byte %h at %0t, nothing was expected",
						data_out, $time);
					errors++;
				end else begin
					want = expect_q.pop_front();
					if (data_out !== want) begin
						$display("FAILED at %0t: data_out %h, expected %h",
							$time, data_out, want);
						errors++;
					end
				end
			end
			// ********************
			// buffer occupancy
			// ********************
			if (read_signal) begin
				stored = 0;
			end else begin
				full_model = (stored == FIFO_DEPTH);
				if (fifo_full !== full_model) begin
					$display("FAILED at %0t: fifo_full %b, expected %b",
						$time, fifo_full, full_model);
					errors++;
				end
				if (data_in_valid && write_signal && !full_model) begin
					stored++;
				end
			end
		end
		pending = expect_q.size();
	end

endmodule

/* logic/rle_encoder.sv */
`timescale 1ns/1ps

module rle_encoder (
	input  logic                data_clk,
	input  logic                reset,
	input  rle_pkg::data_byte_t data_in,
	input  logic                data_in_valid,
	input  logic                write_signal,
	input  logic                read_signal,
	output rle_pkg::data_byte_t data_out,
	output logic                data_out_valid,
	output logic                fifo_full
);

	import rle_pkg::*;

	logic       write_en;
	data_byte_t head;
	logic       empty;
	logic       pop;
	logic       run_done;
	data_byte_t run_byte;
	run_len_t   run_len;
	logic       busy;

	// both strobes needed to store a byte.
	assign write_en = data_in_valid && write_signal;

	byte_fifo fifo_i (
		.data_clk (data_clk),
		.reset    (reset),
		.data_in  (data_in),
		.write_en (write_en),
		.pop      (pop),
		.head     (head),
		.empty    (empty),
		.full     (fifo_full)
	);

	run_detector detect_i (
		.data_clk    (data_clk),
		.reset       (reset),
		.read_signal (read_signal),
		.head        (head),
		.empty       (empty),
		.busy        (busy),
		.pop         (pop),
		.run_done    (run_done),
		.run_byte    (run_byte),
		.run_len     (run_len)
	);

	token_emitter emit_i (
		.data_clk       (data_clk),
		.reset          (reset),
		.run_done       (run_done),
		.run_byte       (run_byte),
		.run_len        (run_len),
		.busy           (busy),
		.data_out       (data_out),
		.data_out_valid (data_out_valid)
	);

endmodule

/* logic/token_emitter.sv */
`timescale 1ns/1ps

module token_emitter (
	input  logic                data_clk,
	input  logic                reset,
	input  logic                run_done,
	input  rle_pkg::data_byte_t run_byte,
	input  rle_pkg::run_len_t   run_len,
	output logic                busy,
	output rle_pkg::data_byte_t data_out,
	output logic                data_out_valid
);

	import rle_pkg::*;

	// bytes still waiting after the one on data_out.
	logic [1:0] pend_cnt;
	data_byte_t next_byte;
	data_byte_t last_byte;

	logic       use_escape;
	data_byte_t first_tok;
	data_byte_t second_tok;
	data_byte_t third_tok;
	logic [1:0] first_pend;

	// ********************
	// token form
	// ********************

	// escape byte itself is never sent literally.
	assign use_escape = (run_byte == ESCAPE_BYTE) || (run_len > run_len_t'(2));

	always_comb begin
		first_tok  = run_byte;
		second_tok = run_byte;
		third_tok  = run_byte;
		first_pend = 2'd0;
		if (use_escape) begin
			first_tok  = ESCAPE_BYTE;
			second_tok = run_len;
			first_pend = 2'd2;
		end else if (run_len == run_len_t'(2)) begin
			first_pend = 2'd1;
		end
	end

	// low during the last byte so runs go back to back.
	assign busy = (pend_cnt != 2'd0);

	// ********************
	// shift out
	// ********************

	always_ff @(posedge data_clk) begin
		if (reset) begin
			pend_cnt       <= 2'd0;
			data_out_valid <= 1'b0;
		end else if (run_done) begin
			pend_cnt       <= first_pend;
			data_out_valid <= 1'b1;
		end else if (pend_cnt != 2'd0) begin
			pend_cnt       <= pend_cnt - 2'd1;
			data_out_valid <= 1'b1;
		end else begin
			data_out_valid <= 1'b0;
		end
	end

	always_ff @(posedge data_clk) begin
		if (run_done) begin
			data_out  <= first_tok;
			next_byte <= second_tok;
			last_byte <= third_tok;
		end else if (pend_cnt != 2'd0) begin
			data_out  <= next_byte;
			next_byte <= last_byte;
		end
	end

	run_len_nonzero_a: assert property (
		@(posedge data_clk) disable iff (reset)
		run_done |-> (run_len != '0)
	);

endmodule

/* logic/run_detector.sv */
`timescale 1ns/1ps

module run_detector (
	input  logic                data_clk,
	input  logic                reset,
	input  logic                read_signal,
	input  rle_pkg::data_byte_t head,
	input  logic                empty,
	input  logic                busy,
	output logic                pop,
	output logic                run_done,
	output rle_pkg::data_byte_t run_byte,
	output rle_pkg::run_len_t   run_len
);

	import rle_pkg::*;

	detect_state_t state;
	detect_state_t state_next;

	logic load_new;
	logic extend;
	logic same_byte;
	logic at_max;

	assign same_byte = (head == run_byte);
	assign at_max    = (run_len == run_len_t'(MAX_RUN));

	// ********************
	// next state
	// ********************

	always_comb begin
		state_next = state;
		pop        = 1'b0;
		run_done   = 1'b0;
		load_new   = 1'b0;
		extend     = 1'b0;
		case (state)
			idle: begin
				if (read_signal && !busy && !empty) begin
					pop        = 1'b1;
					load_new   = 1'b1;
					state_next = collect;
				end
			end
			collect: begin
				if (read_signal && empty) begin
					state_next = flush_wait;
				end else if (read_signal && !busy) begin
					pop = 1'b1;
					if (same_byte && !at_max) begin
						extend = 1'b1;
					end else begin
						// closing byte opens the next run.
						run_done = 1'b1;
						load_new = 1'b1;
					end
				end
			end
			flush_wait: begin
				// a late byte keeps the run going.
				if (!empty) begin
					state_next = collect;
				end else if (read_signal && !busy) begin
					run_done   = 1'b1;
					state_next = idle;
				end
			end
			default: begin
				state_next = idle;
			end
		endcase
	end

	// ********************
	// registers
	// ********************

	always_ff @(posedge data_clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge data_clk) begin
		if (load_new) begin
			run_byte <= head;
			run_len  <= run_len_t'(1);
		end else if (extend) begin
			run_len <= run_len + run_len_t'(1);
		end
	end

	// emitter must be free before a run is handed over.
	run_done_not_busy_a: assert property (
		@(posedge data_clk) disable iff (reset)
		run_done |-> !busy
	);

endmodule

/* logic/byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo (
	input  logic                data_clk,
	input  logic                reset,
	input  rle_pkg::data_byte_t data_in,
	input  logic                write_en,
	input  logic                pop,
	output rle_pkg::data_byte_t head,
	output logic                empty,
	output logic                full
);

	import rle_pkg::*;

	data_byte_t  mem [FIFO_DEPTH];
	fifo_ptr_t   wr_ptr;
	fifo_ptr_t   rd_ptr;
	fifo_count_t count;

	logic do_write;
	logic do_pop;

	// ********************
	// flags
	// ********************

	assign empty = (count == '0);
	assign full  = (count == fifo_count_t'(FIFO_DEPTH));

	// writes into a full buffer are lost.
	assign do_write = write_en && !full;
	assign do_pop   = pop && !empty;

	// fall-through head.
	assign head = mem[rd_ptr];

	// ********************
	// storage
	// ********************

	always_ff @(posedge data_clk) begin
		if (do_write) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// pointers wrap at 256 by width.
	always_ff @(posedge data_clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + fifo_ptr_t'(1);
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + fifo_ptr_t'(1);
			end
			case ({do_write, do_pop})
				2'b10: begin
					count <= count + fifo_count_t'(1);
				end
				2'b01: begin
					count <= count - fifo_count_t'(1);
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

	// ********************
	// checks
	// ********************

	// the detector must only pop a non-empty buffer.
	pop_not_empty_a: assert property (
		@(posedge data_clk) disable iff (reset)
		pop |-> !empty
	);

	count_in_range_a: assert property (
		@(posedge data_clk) disable iff (reset)
		count <= fifo_count_t'(FIFO_DEPTH)
	);

endmodule

/* logic/rle_pkg.sv */
package rle_pkg;

	// ********************
	// widths
	// ********************

	// one byte of payload.
	typedef logic [7:0] data_byte_t;

	// run length from 1 to 255 when valid.
	typedef logic [7:0] run_len_t;

	// buffer address.
	typedef logic [7:0] fifo_ptr_t;

	// buffer occupancy from 0 to 256.
	typedef logic [8:0] fifo_count_t;

	// ********************
	// constants
	// ********************

	localparam int unsigned FIFO_DEPTH = 256;

	// a run is forced closed at this length.
	localparam int unsigned MAX_RUN = 255;

	// marks the three-byte token.
	localparam data_byte_t ESCAPE_BYTE = 8'h1B;

	// detector states.
	typedef enum logic [1:0] {
		idle,
		collect,
		flush_wait
	} detect_state_t;

endpackage
